// File: source/uart_pkg.sv
// Bank constants for 8N1 framing only. BAUD_DIV and FIFO_DEPTH must each be at least 2
`default_nettype none

package uart_pkg;

    // Bank size
    localparam int NUM_CH     = 4;                  // Transmit lanes
    localparam int CH_W       = 2;                  // Channel number width

    // Per lane buffering
    localparam int FIFO_DEPTH = 4;                  // Bytes queued behind the shifter
    localparam int DATA_W     = 8;                  // Byte payload

    // Serial timing
    localparam int BAUD_DIV   = 8;                  // clk cycles per bit, small for sim
    localparam int FRAME_BITS = DATA_W + 2;         // Start, data LSB first, stop

    // Derived widths
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int BAUD_W     = $clog2(BAUD_DIV);
    localparam int BIT_W      = $clog2(FRAME_BITS);

endpackage

`default_nettype wire

// File: source/tx_dispatch.sv
// Adds one cycle of latency and drops requests whose channel number exceeds NUM_CH-1
`default_nettype none

module tx_dispatch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        send,     // One-cycle host strobe
    input  logic [uart_pkg::CH_W-1:0]   chan,
    input  logic [uart_pkg::DATA_W-1:0] data,
    output logic [uart_pkg::NUM_CH-1:0] wr,       // One-hot lane write
    output logic [uart_pkg::DATA_W-1:0] wr_data,  // Shared by all lanes
    output logic                        bad_chan  // Sticky until reset
);
    import uart_pkg::*;

    logic              in_range;
    logic [NUM_CH-1:0] wr_next;

    // Never false while chan is 2 bits and NUM_CH is 4
    assign in_range = (int'(chan) < NUM_CH);

    // Channel decode
    always_comb begin
        wr_next = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (send && in_range && (int'(chan) == i)) begin
                wr_next[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr       <= '0;
            bad_chan <= 1'b0;
        end else begin
            wr <= wr_next;              // send at t gives wr at t+1
            if (send && !in_range) begin
                bad_chan <= 1'b1;       // Write already suppressed by decode
            end
        end
    end

    // Byte follows the strobe
    always_ff @(posedge clk) begin
        if (send) wr_data <= data;
    end

endmodule

`default_nettype wire

// File: source/tx_fifo.sv
// Byte FIFO on one clock that drops writes when full and ignores reads when empty
`default_nettype none

module tx_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr,
    input  logic [uart_pkg::DATA_W-1:0] wr_data,
    input  logic                        rd,
    output logic [uart_pkg::DATA_W-1:0] rd_data,  // Head entry
    output logic                        full,
    output logic                        empty
);
    import uart_pkg::*;

    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;   // Occupancy
    logic                  do_wr;
    logic                  do_rd;

    // Pointer advance with wrap for any depth
    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
        if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr && !full;      // Overflow dropped here
    assign do_rd   = rd && !empty;
    assign rd_data = mem[rd_ptr];      // Show-ahead

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // Pointers and count
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/uart_tx_lane.sv
// One 8N1 transmitter with fixed BAUD_DIV and one stop bit, plus one idle cycle between frames
`default_nettype none

module uart_tx_lane (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr,         // Queue wr_data
    input  logic [uart_pkg::DATA_W-1:0] wr_data,
    output logic                        txd,        // Idle high
    output logic                        busy,
    output logic                        full,
    output logic                        frame_done  // Last cycle of stop bit
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'b00,   // Waiting for a queued byte
        LOAD = 2'b01,   // Frame load, first start bit cycle
        SEND = 2'b10    // Shifting out
    } state_t;

    state_t                state;
    logic [DATA_W-1:0]     fifo_data;
    logic                  fifo_empty;
    logic                  pop;
    logic [DATA_W-1:0]     byte_q;      // Popped byte
    logic [FRAME_BITS-1:0] shreg;       // Frame shifter, LSB on the line
    logic [BAUD_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  tick;        // Bit boundary
    logic                  last_bit;

    tx_fifo i_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .wr_data (wr_data),
        .rd      (pop),
        .rd_data (fifo_data),
        .full    (full),
        .empty   (fifo_empty)
    );

    assign pop        = (state == IDLE) && !fifo_empty;
    assign tick       = (state == SEND) && (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign last_bit   = (bit_cnt == BIT_W'(FRAME_BITS - 1));   // Stop bit
    assign frame_done = tick && last_bit;
    assign busy       = (state != IDLE);

    // Line driver
    always_comb begin
        case (state)
            LOAD:    txd = 1'b0;        // Start bit begins here
            SEND:    txd = shreg[0];
            default: txd = 1'b1;
        endcase
    end

    // FSM and counters
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) state <= LOAD;
                end
                LOAD: begin
                    state    <= SEND;
                    baud_cnt <= BAUD_W'(1);     // LOAD counted as start bit cycle
                    bit_cnt  <= '0;
                end
                SEND: begin
                    if (tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (last_bit) state <= IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (pop) byte_q <= fifo_data;
        if (state == LOAD) begin
            shreg <= {1'b1, byte_q, 1'b0};              // Stop, data, start
        end else if (tick) begin
            shreg <= {1'b1, shreg[FRAME_BITS-1:1]};     // Idle level shifted in
        end
    end

endmodule

`default_nettype wire

// File: source/tx_done_collector.sv
// Serializes simultaneous lane completions, so a done can lag its frame by up to NUM_CH cycles
`default_nettype none

module tx_done_collector (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [uart_pkg::NUM_CH-1:0] frame_done, // Per lane pulses
    output logic                        done,
    output logic [uart_pkg::CH_W-1:0]   done_chan
);
    import uart_pkg::*;

    logic [NUM_CH-1:0] pending;     // One flag per lane
    logic [CH_W-1:0]   ptr;         // Round-robin start point
    logic              grant_vld;
    logic [CH_W-1:0]   grant_idx;
    logic [NUM_CH-1:0] grant_mask;

    // Lowest pending index at or after ptr
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            idx = int'(ptr) + i;
            if (idx >= NUM_CH) idx = idx - NUM_CH;  // Wrap
            if (!grant_vld && pending[idx]) begin
                grant_vld = 1'b1;
                grant_idx = CH_W'(idx);
            end
        end
    end

    assign grant_mask = grant_vld ? (NUM_CH'(1) << grant_idx) : '0;
    assign done       = grant_vld;
    assign done_chan  = grant_idx;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pending <= '0;
            ptr     <= '0;
        end else begin
            // New pulse on the granted lane survives the clear
            pending <= (pending & ~grant_mask) | frame_done;
            if (grant_vld) begin
                if (grant_idx == CH_W'(NUM_CH - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= grant_idx + 1'b1;    // Start after the winner
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/uart_tx_bank.sv
// Bank of NUM_CH independent 8N1 transmitters behind one byte port, with no receive path
`default_nettype none

module uart_tx_bank (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        send,       // One-cycle strobe
    input  logic [uart_pkg::CH_W-1:0]   chan,
    input  logic [uart_pkg::DATA_W-1:0] data,
    output logic [uart_pkg::NUM_CH-1:0] txd,        // Serial lines, idle high
    output logic [uart_pkg::NUM_CH-1:0] busy,
    output logic [uart_pkg::NUM_CH-1:0] full,
    output logic                        done,       // End of frame pulse
    output logic [uart_pkg::CH_W-1:0]   done_chan,
    output logic                        bad_chan
);
    import uart_pkg::*;

    logic [NUM_CH-1:0] wr;          // One-hot lane write
    logic [DATA_W-1:0] wr_data;
    logic [NUM_CH-1:0] frame_done;

    tx_dispatch i_dispatch (
        .clk      (clk),
        .rst      (rst),
        .send     (send),
        .chan     (chan),
        .data     (data),
        .wr       (wr),
        .wr_data  (wr_data),
        .bad_chan (bad_chan)
    );

    // Identical lanes
    for (genvar g = 0; g < NUM_CH; g++) begin : g_lane
        uart_tx_lane i_lane (
            .clk        (clk),
            .rst        (rst),
            .wr         (wr[g]),
            .wr_data    (wr_data),
            .txd        (txd[g]),
            .busy       (busy[g]),
            .full       (full[g]),
            .frame_done (frame_done[g])
        );
    end

    tx_done_collector i_collector (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .done       (done),
        .done_chan  (done_chan)
    );

endmodule

`default_nettype wire

// File: verif/uart_tx_bank_properties.sv
// Checks only top level ports plus the lane write strobe, and stays quiet while rst is low
`default_nettype none

module uart_tx_bank_properties (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [uart_pkg::NUM_CH-1:0] txd,
    input  logic [uart_pkg::NUM_CH-1:0] busy,
    input  logic [uart_pkg::NUM_CH-1:0] full,
    input  logic [uart_pkg::NUM_CH-1:0] wr,         // Dispatcher strobe
    input  logic                        done,
    input  logic [uart_pkg::CH_W-1:0]   done_chan
);
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    for (genvar g = 0; g < NUM_CH; g++) begin : g_chk
        // Idle lane keeps the line at mark level
        idle_line_high : assert property (@(posedge clk) disable iff (!rst)
            !busy[g] |-> txd[g])
            else $error("Lane %0d drives txd low while not busy", g);

        // FIFO fills only by a write one cycle earlier
        full_needs_write : assert property (@(posedge clk) disable iff (!rst)
            $rose(full[g]) |-> $past(wr[g]))
            else $error("Lane %0d full rose without a write", g);
    end

    no_repeat_done : assert property (@(posedge clk) disable iff (!rst)
        done |=> !(done && (done_chan == $past(done_chan))))
        else $error("Two done pulses in a row for one channel");

endmodule

bind uart_tx_bank uart_tx_bank_properties i_props (
    .clk       (clk),
    .rst       (rst),
    .txd       (txd),
    .busy      (busy),
    .full      (full),
    .wr        (wr),
    .done      (done),
    .done_chan (done_chan)
);

`default_nettype wire

// File: verif/tb_uart_tx_bank.sv
// Decoder assumes BAUD_DIV is even and at most 63 bytes in flight per channel
`default_nettype none

module tb_uart_tx_bank;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    localparam int FRAME_CYC    = FRAME_BITS * BAUD_DIV;
    localparam int IDLE_TIMEOUT = 2000;            // Cycles per idle wait

    logic              clk;
    logic              rst;
    logic              send;
    logic [CH_W-1:0]   chan;
    logic [DATA_W-1:0] data;
    logic [NUM_CH-1:0] txd;
    logic [NUM_CH-1:0] busy;
    logic [NUM_CH-1:0] full;
    logic              done;
    logic [CH_W-1:0]   done_chan;
    logic              bad_chan;

    int         seed      = 32'h70cf_de64;
    string      test_name = "reset";
    int         err_main  = 0;                     // Stimulus side checks
    int         err_rx;                            // Line decoder checks
    logic [7:0] exp_mem   [NUM_CH][64];            // Expected bytes, ring per channel
    logic [5:0] exp_wr    [NUM_CH];
    logic [5:0] exp_rd    [NUM_CH];
    logic       rx_active [NUM_CH];                // Frame in progress
    logic       rx_prev   [NUM_CH];
    int         rx_cnt    [NUM_CH];                // Cycles since start edge
    logic [7:0] rx_sh     [NUM_CH];
    int         decoded   [NUM_CH];
    int         done_cnt  [NUM_CH];

    uart_tx_bank i_dut (
        .clk       (clk),
        .rst       (rst),
        .send      (send),
        .chan      (chan),
        .data      (data),
        .txd       (txd),
        .busy      (busy),
        .full      (full),
        .done      (done),
        .done_chan (done_chan),
        .bad_chan  (bad_chan)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                    // 40 ns period
    end

    // Serial line model, samples mid-bit on falling edges
    always @(negedge clk) begin
        int bitn;
        if (!rst) begin
            err_rx = 0;
            for (int c = 0; c < NUM_CH; c++) begin
                rx_active[c] = 1'b0;
                rx_prev[c]   = 1'b1;
                rx_cnt[c]    = 0;
                exp_rd[c]    = '0;
                decoded[c]   = 0;
                done_cnt[c]  = 0;
            end
        end else begin
            if (done) done_cnt[done_chan]++;
            for (int c = 0; c < NUM_CH; c++) begin
                if (!rx_active[c]) begin
                    if (rx_prev[c] && !txd[c]) begin   // Start edge
                        rx_active[c] = 1'b1;
                        rx_cnt[c]    = 0;
                    end
                end else begin
                    rx_cnt[c]++;
                    if (rx_cnt[c] % BAUD_DIV == BAUD_DIV / 2) begin
                        bitn = rx_cnt[c] / BAUD_DIV;
                        if (bitn == 0) begin
                            if (txd[c]) begin
                                err_rx++;
                                $display("Start bit on channel %0d did not hold low", c);
                                rx_active[c] = 1'b0;
                            end
                        end else if (bitn < FRAME_BITS - 1) begin
                            rx_sh[c] = {txd[c], rx_sh[c][7:1]};   // LSB first
                        end else begin
                            if (!txd[c]) begin
                                err_rx++;
                                $display("ERROR %s ch%0d stop bit: expected 1, actual 0",
                                         test_name, c);
                            end
                            if (exp_rd[c] == exp_wr[c]) begin
                                err_rx++;
                                $display("Channel %0d sent a frame nobody asked for", c);
                            end else begin
                                if (rx_sh[c] !== exp_mem[c][exp_rd[c]]) begin
                                    err_rx++;
                                    $display("ERROR %s ch%0d byte: expected %h, actual %h",
                                             test_name, c, exp_mem[c][exp_rd[c]], rx_sh[c]);
                                end
                                exp_rd[c]++;
                            end
                            decoded[c]++;
                            rx_active[c] = 1'b0;
                        end
                    end
                end
                rx_prev[c] = txd[c];
            end
        end
    end

    task automatic check_value(input string what, input logic [7:0] act,
                               input logic [7:0] exp);
        if (act !== exp) begin
            err_main++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Drives one send cycle, queues the byte if the model expects it on the line
    task automatic send_byte(input logic [CH_W-1:0] ch, input logic [7:0] b,
                             input bit accept);
        @(negedge clk);
        send = 1'b1;
        chan = ch;
        data = b;
        if (accept) begin
            exp_mem[ch][exp_wr[ch]] = b;
            exp_wr[ch]++;
        end
    endtask

    task automatic end_send();
        @(negedge clk);
        send = 1'b0;
    endtask

    task automatic report_counts();
        $display("Error count: %0d stimulus checks, %0d line checks", err_main, err_rx);
    endtask

    // All lanes quiet for 8 cycles, so late done pulses are counted too
    task automatic wait_all_idle();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 8 && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (busy == '0) quiet++;
            else quiet = 0;
        end
        if (quiet < 8) begin
            err_main++;
            $display("Lanes still busy when the idle wait in %s timed out", test_name);
        end
    endtask

    initial begin
        logic [CH_W-1:0] ch;
        bit              saw_full;
        rst  = 1'b0;
        send = 1'b0;
        chan = '0;
        data = '0;
        for (int c = 0; c < NUM_CH; c++) exp_wr[c] = '0;
        repeat (2) @(negedge clk);
        rst = 1'b1;

        @(negedge clk);
        check_value("txd", 8'(txd), 8'({NUM_CH{1'b1}}));
        check_value("busy", 8'(busy), 8'h00);
        check_value("full", 8'(full), 8'h00);
        check_value("done", 8'(done), 8'h00);
        check_value("bad_chan", 8'(bad_chan), 8'h00);

        test_name = "single";
        for (int n = 0; n < 12; n++) begin
            ch = CH_W'($random(seed));
            send_byte(ch, 8'($random(seed)), 1'b1);
            end_send();
            repeat (FRAME_CYC + 2 + ($random(seed) & 31)) @(negedge clk);
        end
        wait_all_idle();

        test_name = "parallel";
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 2 * NUM_CH; k++) begin   // Two bytes per lane
                send_byte(CH_W'(k), 8'($random(seed)), 1'b1);
            end
            end_send();
            wait_all_idle();
        end

        test_name = "overflow";
        ch       = CH_W'($random(seed));
        saw_full = 1'b0;
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            send_byte(ch, 8'($random(seed)), k < FIFO_DEPTH + 1);   // Tail dropped
            if (full[ch]) saw_full = 1'b1;
        end
        end_send();
        @(negedge clk);
        if (full[ch]) saw_full = 1'b1;
        check_value("full seen", 8'(saw_full), 8'h01);
        wait_all_idle();

        test_name = "completions";
        for (int c = 0; c < NUM_CH; c++) begin
            check_value($sformatf("done count ch%0d", c), 8'(done_cnt[c]), 8'(decoded[c]));
            if (exp_rd[c] != exp_wr[c]) begin
                err_main++;
                $display("Channel %0d: some sent bytes never appeared on the line", c);
            end
        end
        check_value("bad_chan", 8'(bad_chan), 8'h00);

        report_counts();
        if (err_main + err_rx == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/uart_pkg.sv
source/tx_dispatch.sv
source/tx_fifo.sv
source/uart_tx_lane.sv
source/tx_done_collector.sv
source/uart_tx_bank.sv
verif/uart_tx_bank_properties.sv
verif/tb_uart_tx_bank.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the UART bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_uart_tx_bank \
    -f compile.f \
    --Mdir obj_dir -o tb_uart_tx_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/tb_uart_tx_bank 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
